/* source/raster_pkg.sv */
// Fixed-point widths and packed types shared by the triangle bounding-box stage
// Modules import this package inside their bodies and use scoped names in port lists
// Coordinates are signed, with 14 integer bits above 10 fraction bits
package raster_pkg;

    // Coordinate word and its fraction part
    localparam int coord_w = 24;
    localparam int radix_w = 10;

    // Register stages in the box path
    // The vertex delay line is sized from this so both paths stay aligned
    localparam int bbox_depth = 2;

    // One signed fixed-point coordinate
    typedef logic signed [coord_w-1:0] coord_t;

    // One-hot multisample select
    // Bit 3 for 1x, bit 2 for 4x, bit 1 for 16x, bit 0 for 64x
    typedef logic [3:0] msaa_t;

    // Vertex position, z rides along untouched
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // Three vertices in input order
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    // Axis-aligned box
    // Lower left corner then upper right corner
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } box_t;

    // Largest legal sample position on each axis
    // Held constant while triangles are in flight
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

endpackage

/* source/bbox_find.sv */
// First box stage of the rasterizer front end
// Takes a triangle and registers the min and max x and y of its vertices
// Advances on every edge where stall is low, holds otherwise
`timescale 1ns/1ps

module bbox_find (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  raster_pkg::tri_t tri_in,
    input  logic             valid_in,
    output raster_pkg::box_t box,
    output logic             valid
);

    import raster_pkg::*;

    // Unregistered box from the current input
    box_t box_next;

    // Smallest of three coordinates
    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (b < a) ? b : a;
        // Ties keep the earlier vertex, value is the same either way
        if (c < m) begin
            m = c;
        end
        return m;
    endfunction

    // Largest of three coordinates
    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (b > a) ? b : a;
        if (c > m) begin
            m = c;
        end
        return m;
    endfunction

    // Min and max per axis
    // z plays no part in the box
    always_comb begin
        box_next.ll_x = min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_next.ll_y = min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
        box_next.ur_x = max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x);
        box_next.ur_y = max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y);
    end

    // Box payload register
    // Only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (!stall) begin
            box <= box_next;
        end
    end

    // Valid bit follows the input slot on unstalled edges
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in;
        end
    end

endmodule

/* source/sample_snap_clip.sv */
// Second box stage of the rasterizer front end
// Floors the box corners to the multisample grid, clamps them to the screen
// and drops boxes that lie wholly off screen
// Advances on every edge where stall is low, holds otherwise
`timescale 1ns/1ps

module sample_snap_clip (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  raster_pkg::box_t    box_in,
    input  logic                valid_in,
    input  raster_pkg::screen_t screen,
    input  raster_pkg::msaa_t   msaa,
    output raster_pkg::box_t    box,
    output logic                valid
);

    import raster_pkg::*;

    // Fraction bits that survive the floor
    logic [radix_w-1:0] frac_mask;

    // Box after flooring to the sample grid
    box_t box_floor;

    // Box after clamping to the screen
    box_t box_clamp;

    // Accept decision for this slot
    logic keep;

    // Integer part passes, fraction is masked
    // Clearing low bits of a two's complement value rounds toward minus infinity
    function automatic coord_t floor_coord(input coord_t c, input logic [radix_w-1:0] m);
        return {c[coord_w-1:radix_w], c[radix_w-1:0] & m};
    endfunction

    // Grid step from the one-hot sample setting
    // 1x keeps no fraction bits, 4x one, 16x two, 64x three
    always_comb begin
        frac_mask = '0;
        frac_mask[radix_w-1] = msaa[2] | msaa[1] | msaa[0];
        frac_mask[radix_w-2] = msaa[1] | msaa[0];
        frac_mask[radix_w-3] = msaa[0];
    end

    // Snap all four corners
    always_comb begin
        box_floor.ll_x = floor_coord(box_in.ll_x, frac_mask);
        box_floor.ll_y = floor_coord(box_in.ll_y, frac_mask);
        box_floor.ur_x = floor_coord(box_in.ur_x, frac_mask);
        box_floor.ur_y = floor_coord(box_in.ur_y, frac_mask);
    end

    // Clamp lower left up to the origin
    // Clamp upper right down to the screen limits
    always_comb begin
        box_clamp.ll_x = (box_floor.ll_x < 0) ? '0 : box_floor.ll_x;
        box_clamp.ll_y = (box_floor.ll_y < 0) ? '0 : box_floor.ll_y;
        box_clamp.ur_x = (box_floor.ur_x > screen.width)  ? screen.width  : box_floor.ur_x;
        box_clamp.ur_y = (box_floor.ur_y > screen.height) ? screen.height : box_floor.ur_y;
    end

    // Reject when the box sits left of or below the origin
    // or right of or above the screen
    // A partly visible box passes with its clamped corners
    always_comb begin
        keep = valid_in;
        if (box_floor.ur_x < 0 || box_floor.ur_y < 0) begin
            keep = 1'b0;
        end
        if (box_floor.ll_x > screen.width || box_floor.ll_y > screen.height) begin
            keep = 1'b0;
        end
    end

    // Clamped box register, no reset on payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            box <= box_clamp;
        end
    end

    // Output valid, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= keep;
        end
    end

endmodule

/* source/tri_delay.sv */
// Delay line that carries triangle vertices beside the box pipeline
// depth must match the number of box register stages
// Shifts on every edge where stall is low, holds otherwise
`timescale 1ns/1ps

module tri_delay #(
    parameter int depth = 2
) (
    input  logic             clk,
    input  logic             stall,
    input  raster_pkg::tri_t tri_in,
    output raster_pkg::tri_t tri_out
);

    import raster_pkg::*;

    // One triangle register per stage
    // Entry 0 is loaded from the input, the last entry drives the output
    tri_t stage_q [depth];

    // Whole chain shifts together on unstalled edges
    // Validity travels in the box path beside it
    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_q[0] <= tri_in;
            for (int i = 1; i < depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Oldest entry leaves the line
    assign tri_out = stage_q[depth-1];

endmodule

/* source/bbox_stage.sv */
// Bounding-box stage of the triangle rasterizer
// A triangle taken on an unstalled edge leaves two unstalled edges later
// with its floored and clamped box, or with out_valid low if rejected
// stall high freezes every register, there is no ready back to the source
`timescale 1ns/1ps

module bbox_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  raster_pkg::tri_t    in_tri,
    input  logic                in_valid,
    input  raster_pkg::screen_t screen,
    input  raster_pkg::msaa_t   msaa,
    output raster_pkg::tri_t    out_tri,
    output raster_pkg::box_t    out_box,
    output logic                out_valid
);

    import raster_pkg::*;

    // Raw min and max box between the two box stages
    box_t mid_box;
    logic mid_valid;

    // Stage one finds the box corners
    bbox_find bbox_find_i (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .tri_in   (in_tri),
        .valid_in (in_valid),
        .box      (mid_box),
        .valid    (mid_valid)
    );

    // Stage two snaps, clamps and rejects
    sample_snap_clip sample_snap_clip_i (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .box_in   (mid_box),
        .valid_in (mid_valid),
        .screen   (screen),
        .msaa     (msaa),
        .box      (out_box),
        .valid    (out_valid)
    );

    // Vertices travel alongside with matching latency
    tri_delay #(
        .depth (bbox_depth)
    ) tri_delay_i (
        .clk     (clk),
        .stall   (stall),
        .tri_in  (in_tri),
        .tri_out (out_tri)
    );

endmodule

/* verification/bbox_stage_assertions.sv */
// Bound checks on the outputs of the bounding-box stage
// Attached to bbox_stage with bind from the testbench
// Ports carry the same names as the DUT signals they watch
`timescale 1ns/1ps

module bbox_stage_assertions (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input raster_pkg::screen_t screen,
    input raster_pkg::box_t    out_box,
    input raster_pkg::tri_t    out_tri,
    input logic                out_valid
);

    // Lower left never passes upper right on an accepted box
    corner_order: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> (out_box.ll_x <= out_box.ur_x && out_box.ll_y <= out_box.ur_y)
    ) else $error("accepted box has its lower left corner beyond the upper right corner");

    // Clamped corners stay between the origin and the screen limits
    clamp_limits: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> (out_box.ur_x <= screen.width && out_box.ur_y <= screen.height
                       && out_box.ll_x >= 0 && out_box.ll_y >= 0)
    ) else $error("accepted box reaches outside the screen");

    // A stalled edge leaves every output where it was
    // Values sampled before the stalled edge must match those after it
    stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> ($stable(out_valid) && $stable(out_box) && $stable(out_tri))
    ) else $error("outputs changed on an edge where stall was high");

endmodule

/* verification/bbox_stage_tb.sv */
// Self-checking testbench for the triangle bounding-box stage
// Directed and LFSR driven triangles go in on falling edges, a reference model
// predicts every unstalled slot and a shadow queue lines predictions up with outputs
// Random stall bursts check that the pipeline holds and loses nothing
`timescale 1ns/1ps

module bbox_stage_tb;

    import raster_pkg::*;

    // Widest compared value is a whole triangle
    localparam int cmp_w = $bits(tri_t);

    // Unstalled edges from input to output including the taking edge
    localparam int latency = 2;

    // Screen limits in whole pixels
    localparam int scr_w = 640;
    localparam int scr_h = 480;

    // Test sizes
    localparam int n_on = 24;
    localparam int n_cross = 8;
    localparam int n_off = 6;
    localparam int n_rand = 300;

    // Reset and idle, sweep, crossing, off screen, random, then margin
    // A random slot costs at most four stalled cycles plus its own
    localparam int cycle_limit = 8 + 4 * (n_on + 2) + (3 * n_cross + 2) + (5 * n_off + 2)
                               + (5 * n_rand + 2) + 100;

    // Prediction for one input slot
    typedef struct packed {
        logic valid;
        box_t box;
        tri_t tri_val;
    } expect_t;

    // DUT ports
    logic    clk;
    logic    rst;
    logic    stall;
    tri_t    in_tri;
    logic    in_valid;
    screen_t screen;
    msaa_t   msaa;
    tri_t    out_tri;
    box_t    out_box;
    logic    out_valid;

    // Stimulus state
    logic [31:0] lfsr_state;
    int          cycle_count;

    // Scoreboard state written on rising edges and read on falling edges
    expect_t shadow_q [$];
    expect_t popped;
    logic    pop_live;
    logic    edge_stalled;
    logic    edge_in_reset;
    logic    edge_seen;
    int      valid_seen;

    // Outputs as seen on the previous falling edge
    logic    held_valid;
    box_t    held_box;
    tri_t    held_tri;

    bbox_stage bbox_stage_i (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .in_tri    (in_tri),
        .in_valid  (in_valid),
        .screen    (screen),
        .msaa      (msaa),
        .out_tri   (out_tri),
        .out_box   (out_box),
        .out_valid (out_valid)
    );

    bind bbox_stage bbox_stage_assertions bbox_stage_assertions_i (.*);

    // 100 ns period
    always #50 clk = ~clk;

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // Random integer from lo up to but not including lo + span
    function automatic int pick(input int lo, input int span);
        return lo + int'(rand_bits(16) % span);
    endfunction

    // Given integer part plus a random fraction
    function automatic coord_t coord_with_frac(input int whole);
        coord_t c;
        logic [31:0] f;
        f = rand_bits(radix_w);
        c = coord_t'(whole) <<< radix_w;
        c[radix_w-1:0] = f[radix_w-1:0];
        return c;
    endfunction

    // Vertex inside the given integer ranges with a random z
    function automatic vertex_t vertex_in(input int x_lo, input int x_span,
                                          input int y_lo, input int y_span);
        vertex_t v;
        v.x = coord_with_frac(pick(x_lo, x_span));
        v.y = coord_with_frac(pick(y_lo, y_span));
        v.z = coord_with_frac(pick(-512, 1024));
        return v;
    endfunction

    // All three vertices from the same ranges
    function automatic tri_t tri_in_range(input int x_lo, input int x_span,
                                          input int y_lo, input int y_span);
        tri_t t;
        t.v0 = vertex_in(x_lo, x_span, y_lo, y_span);
        t.v1 = vertex_in(x_lo, x_span, y_lo, y_span);
        t.v2 = vertex_in(x_lo, x_span, y_lo, y_span);
        return t;
    endfunction

    // Floor toward minus infinity onto steps of 2**drop
    function automatic coord_t grid_floor(input coord_t c, input int drop);
        return (c >>> drop) <<< drop;
    endfunction

    function automatic coord_t larger(input coord_t a, input coord_t b);
        return (a > b) ? a : b;
    endfunction

    function automatic coord_t smaller(input coord_t a, input coord_t b);
        return (a < b) ? a : b;
    endfunction

    // Expected valid, box and vertices for one slot
    function automatic expect_t ref_model(input tri_t t, input logic v,
                                          input screen_t scr, input msaa_t ms);
        expect_t e;
        coord_t xs [3];
        coord_t ys [3];
        coord_t lo_x;
        coord_t lo_y;
        coord_t hi_x;
        coord_t hi_y;
        int drop;
        int i;
        xs[0] = t.v0.x;
        xs[1] = t.v1.x;
        xs[2] = t.v2.x;
        ys[0] = t.v0.y;
        ys[1] = t.v1.y;
        ys[2] = t.v2.y;
        lo_x = xs[0];
        hi_x = xs[0];
        lo_y = ys[0];
        hi_y = ys[0];
        for (i = 1; i < 3; i++) begin
            lo_x = smaller(lo_x, xs[i]);
            hi_x = larger(hi_x, xs[i]);
            lo_y = smaller(lo_y, ys[i]);
            hi_y = larger(hi_y, ys[i]);
        end
        // Fraction bits kept are 0 at 1x, 1 at 4x, 2 at 16x and 3 at 64x
        case (ms)
            4'b0100: drop = radix_w - 1;
            4'b0010: drop = radix_w - 2;
            4'b0001: drop = radix_w - 3;
            default: drop = radix_w;
        endcase
        lo_x = grid_floor(lo_x, drop);
        lo_y = grid_floor(lo_y, drop);
        hi_x = grid_floor(hi_x, drop);
        hi_y = grid_floor(hi_y, drop);
        // Only a box wholly off screen is dropped
        e.valid = v && hi_x >= 0 && hi_y >= 0 && lo_x <= scr.width && lo_y <= scr.height;
        e.box.ll_x = larger(lo_x, '0);
        e.box.ll_y = larger(lo_y, '0);
        e.box.ur_x = smaller(hi_x, scr.width);
        e.box.ur_y = smaller(hi_y, scr.height);
        e.tri_val = t;
        return e;
    endfunction

    task automatic check_value(input logic [cmp_w-1:0] got, input logic [cmp_w-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // One input slot applied on the falling edge
    task automatic drive_slot(input tri_t t, input logic v, input logic s);
        @(negedge clk);
        in_tri = t;
        in_valid = v;
        stall = s;
    endtask

    // Two idle slots so no valid box meets the new setting in stage two
    task automatic set_msaa(input msaa_t m);
        drive_slot('0, 1'b0, 1'b0);
        drive_slot('0, 1'b0, 1'b0);
        msaa = m;
    endtask

    // Predict every unstalled slot and release the one now at the outputs
    always @(posedge clk) begin
        edge_seen = 1'b1;
        edge_stalled = stall;
        edge_in_reset = rst;
        pop_live = 1'b0;
        if (!rst && !stall) begin
            shadow_q.push_back(ref_model(in_tri, in_valid, screen, msaa));
            if (shadow_q.size() >= latency) begin
                popped = shadow_q.pop_front();
                pop_live = 1'b1;
            end
        end
    end

    // Compare outputs half a cycle after the edge that set them
    always @(negedge clk) begin
        if (edge_seen) begin
            if (edge_in_reset) begin
                check_value(out_valid, 1'b0, "out_valid during reset");
            end else if (edge_stalled) begin
                check_value(out_valid, held_valid, "out_valid moved under stall");
                check_value(out_box, held_box, "out_box moved under stall");
                check_value(out_tri, held_tri, "out_tri moved under stall");
            end else if (pop_live) begin
                check_value(out_valid, popped.valid, "out_valid");
                if (popped.valid) begin
                    check_value(out_box, popped.box, "out_box");
                    check_value(out_tri, popped.tri_val, "out_tri");
                    valid_seen++;
                end
            end else begin
                // On the first edge after reset stage two still holds the reset slot
                check_value(out_valid, 1'b0, "out_valid on first edge after reset");
            end
        end
        held_valid = out_valid;
        held_box = out_box;
        held_tri = out_tri;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: test sequence still running after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    initial begin
        tri_t t;
        int m;
        int burst;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        in_tri = '0;
        in_valid = 1'b0;
        screen.width = coord_t'(scr_w) <<< radix_w;
        screen.height = coord_t'(scr_h) <<< radix_w;
        msaa = 4'b1000;
        lfsr_state = 32'h404d_ade2;
        cycle_count = 0;
        valid_seen = 0;
        edge_seen = 1'b0;
        pop_live = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fully visible triangles at 1x then 4x, 16x and 64x
        for (m = 0; m < 4; m++) begin
            set_msaa(msaa_t'(4'b1000 >> m));
            repeat (n_on) begin
                drive_slot(tri_in_range(8, 600, 8, 440), 1'b1, 1'b0);
            end
        end

        // Both sides crossed, then low side only, then high side only
        set_msaa(4'b0100);
        repeat (n_cross) begin
            t.v0 = vertex_in(-120, 100, -90, 80);
            t.v1 = vertex_in(650, 120, 490, 100);
            t.v2 = vertex_in(0, scr_w, 0, scr_h);
            drive_slot(t, 1'b1, 1'b0);
            t.v1 = vertex_in(100, 400, 100, 300);
            drive_slot(t, 1'b1, 1'b0);
            t.v0 = vertex_in(200, 300, 150, 200);
            t.v1 = vertex_in(650, 120, 490, 100);
            drive_slot(t, 1'b1, 1'b0);
        end

        // Left, right, below, above, then a visible one with in_valid low
        repeat (n_off) begin
            drive_slot(tri_in_range(-300, 299, 0, scr_h), 1'b1, 1'b0);
            drive_slot(tri_in_range(scr_w + 1, 300, 0, scr_h), 1'b1, 1'b0);
            drive_slot(tri_in_range(0, scr_w, -300, 299), 1'b1, 1'b0);
            drive_slot(tri_in_range(0, scr_w, scr_h + 1, 300), 1'b1, 1'b0);
            drive_slot(tri_in_range(0, scr_w, 0, scr_h), 1'b0, 1'b0);
        end

        // Mixed traffic with stall bursts whose slots carry junk that must be ignored
        set_msaa(4'b0010);
        repeat (n_rand) begin
            if (rand_bits(2) == 0) begin
                burst = 1 + int'(rand_bits(2));
                repeat (burst) begin
                    drive_slot(tri_in_range(-192, 1024, -256, 1024), rand_bits(1) != 0, 1'b1);
                end
            end
            drive_slot(tri_in_range(-192, 1024, -256, 1024), rand_bits(3) != 0, 1'b0);
        end

        // Flush the last slots out of the pipeline
        repeat (3) begin
            drive_slot('0, 1'b0, 1'b0);
        end
        @(posedge clk);
        if (valid_seen == 0) begin
            $display("No accepted triangle ever reached the outputs");
            $display("** FAIL **");
            $fatal(1, "no output seen");
        end else begin
            $display("Compared %0d accepted triangles", valid_seen);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* sim.f */
source/raster_pkg.sv
source/bbox_find.sv
source/sample_snap_clip.sv
source/tri_delay.sv
source/bbox_stage.sv
verification/bbox_stage_assertions.sv
verification/bbox_stage_tb.sv

/* Bender.yml */
package:
  name: bbox_stage

sources:
  # Design, package first
  - target: rtl
    files:
      - source/raster_pkg.sv
      - source/bbox_find.sv
      - source/sample_snap_clip.sv
      - source/tri_delay.sv
      - source/bbox_stage.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/bbox_stage_assertions.sv
      - verification/bbox_stage_tb.sv
